// ==== decode_top.f ====
design/arm_isa_pkg.sv
design/arm_pipe_pkg.sv
design/insn_classifier.sv
design/operand_shifter.sv
design/reg_file.sv
design/decode_stage.sv
design/decode_top.sv
test/decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= decode_tb
FILELIST ?= decode_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: compile
	./$(SIM) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;
	import arm_isa_pkg::*;
	import arm_pipe_pkg::*;

	localparam int num_random = 300;
	localparam int stim_len = 8 + 4 + 20 + 64 + 8 + num_random;  // Resets, loads, directed, stall, random
	localparam int cycle_limit = 2 * stim_len + 100;
	localparam logic [4:0] imm_amts [4] = '{5'd0, 5'd1, 5'd17, 5'd31};
	localparam logic [3:0] amount_regs [4] = '{4'd10, 4'd13, 4'd11, 4'd12};  // 0, 7, 32, 40

	logic clk;
	logic reset;
	logic stall;
	decode_in_t fetch;
	logic wr_en;
	reg_addr_t wr_addr;
	logic [31:0] wr_data;
	decode_out_t issue;

	insn_class_t cur_class;        // Class the stimulus word was built for
	decode_out_t expect_now;
	logic [31:0] shadow [15];      // What r0 to r14 should hold
	integer seed;
	int errors = 0;
	int cycles = 0;

	decode_top u_decode_top (
		.clk     (clk),
		.reset   (reset),
		.stall   (stall),
		.fetch   (fetch),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.issue   (issue)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 15; i++)
				shadow[i] <= 32'd0;
		end
		else if (wr_en && wr_addr != 4'd15)
			shadow[wr_addr] <= wr_data;
	end

	function automatic logic [31:0] read_model(logic [3:0] idx, logic [31:0] pc_val);
		if (idx == 4'd15)
			return pc_val;
		return shadow[idx];
	endfunction

	function automatic logic [31:0] rotate_right(logic [31:0] x, int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Carry on top of the 32-bit result
	function automatic logic [32:0] shift_model(logic [31:0] v, logic [1:0] kind, int amt,
		logic rrx, logic cin);
		logic [31:0] t;
		if (rrx)
			return {v[0], cin, v[31:1]};
		if (amt == 0)
			return {cin, v};
		case (kind)
			2'd0:
			begin
				t = v << (amt - 1);
				return {t[31], v << amt};
			end
			2'd1:
			begin
				t = v >> (amt - 1);
				return {t[0], v >> amt};
			end
			2'd2:
			begin
				t = $signed(v) >>> (amt - 1);
				return {t[0], $signed(v) >>> amt};
			end
			default:
			begin
				t = rotate_right(v, amt % 32);   // The last bit out lands in bit 31
				return {t[31], t};
			end
		endcase
	endfunction

	function automatic decode_out_t model_decode(decode_in_t f, insn_class_t cls);
		decode_out_t o;
		logic [31:0] w;
		logic [31:0] pc_read;
		logic [31:0] rn_val;
		logic [31:0] rm_val;
		logic [31:0] rs_val;
		logic [31:0] rd_val;
		logic [32:0] sh;
		logic cin;
		int amt;
		w = f.insn;
		cin = f.cpsr[cpsr_c_bit];
		pc_read = f.pc + ((cls == class_alu && !w[25] && w[4]) ? 32'd12 : 32'd8);
		rn_val = read_model(w[19:16], pc_read);
		rm_val = read_model(w[3:0], pc_read);
		rs_val = read_model(w[11:8], 32'd0);      // Port 2 reads zero for r15
		rd_val = read_model(w[15:12], 32'd0);
		if (w[4])
			amt = int'(rs_val[7:0]);
		else if (w[11:7] == 5'd0 && (w[6:5] == 2'd1 || w[6:5] == 2'd2))
			amt = 32;
		else
			amt = int'(w[11:7]);
		sh = shift_model(rm_val, w[6:5], amt, !w[4] && w[11:7] == 5'd0 && w[6:5] == 2'd3, cin);
		o = '0;
		o.valid = f.valid;
		o.cpsr = f.cpsr;
		o.spsr = f.spsr;
		case (cls)
			class_alu:
			begin
				o.op0 = rn_val;
				if (w[25])
				begin
					o.op1 = rotate_right({24'd0, w[7:0]}, 2 * int'(w[11:8]));
					o.carry = cin;
				end
				else
					{o.carry, o.op1} = sh;
			end
			class_ldrstr:
			begin
				o.op0 = rn_val;
				o.op2 = rd_val;
				if (w[25])
					{o.carry, o.op1} = sh;
				else
				begin
					o.op1 = {20'd0, w[11:0]};
					o.carry = cin;
				end
			end
			class_ldmstm:
			begin
				o.op0 = rn_val;
				o.op1 = {16'd0, w[15:0]};
			end
			class_hdata_imm:
			begin
				o.op0 = rn_val;
				o.op1 = {24'd0, w[11:8], w[3:0]};
				o.op2 = rd_val;
			end
			class_branch:
				o.op0 = 32'($signed(w[23:0])) * 4;   // Byte distance of a signed word offset
			default:
				o.op0 = 32'd0;
		endcase
		return o;
	endfunction

	always_comb
		expect_now = model_decode(fetch, cur_class);

	check_accepted: assert property (@(posedge clk) disable iff (reset)
		(fetch.valid && !stall) |=> issue == $past(expect_now))
	else
	begin
		errors = errors + 1;
		$display("Error at %0t: issue does not match the model for the accepted instruction", $time);
	end

	check_stall: assert property (@(posedge clk) disable iff (reset) stall |=> $stable(issue))
	else
	begin
		errors = errors + 1;
		$display("Error at %0t: issue changed while stall was high", $time);
	end

	check_idle: assert property (@(posedge clk) disable iff (reset)
		(!fetch.valid && !stall) |=> !issue.valid)
	else
	begin
		errors = errors + 1;
		$display("Error at %0t: issue.valid stayed high after an idle input cycle", $time);
	end

	check_reset: assert property (@(posedge clk) reset |=> issue == '0)
	else
	begin
		errors = errors + 1;
		$display("Error at %0t: issue is not cleared by reset", $time);
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: the run did not end within %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] force_bits(logic [31:0] base, logic [31:0] mask,
		logic [31:0] value);
		return (base & ~mask) | (value & mask);
	endfunction

	task automatic offer(input logic [31:0] word, input insn_class_t cls, input logic hold);
		@(posedge clk);
		fetch.valid <= 1'b1;
		fetch.insn <= insn_word_t'(word);
		fetch.pc <= $random(seed) & 32'hffff_fffc;
		fetch.cpsr <= $random(seed);
		fetch.spsr <= $random(seed);
		cur_class <= cls;
		stall <= hold;
		wr_en <= 1'b0;
	endtask

	task automatic idle();
		@(posedge clk);
		fetch.valid <= 1'b0;
		stall <= 1'b0;
		wr_en <= 1'b0;
	endtask

	task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
		@(posedge clk);
		fetch.valid <= 1'b0;
		stall <= 1'b0;
		wr_en <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
	endtask

	initial
	begin
		int pick;
		logic hold;
		logic [31:0] word;
		seed = 45866;
		reset = 1'b1;
		stall = 1'b0;
		fetch = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		cur_class = class_undefined;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// A second reset arrives while the stage register holds a live result
		offer(32'he281_0001, class_alu, 1'b0);
		@(posedge clk);
		reset <= 1'b1;
		fetch.valid <= 1'b0;
		@(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < 15; i++)
			write_reg(4'(i), $random(seed));
		write_reg(4'd15, 32'hdead_beef);   // Must not reach any register
		write_reg(4'd10, 32'd0);
		write_reg(4'd11, 32'd32);
		write_reg(4'd12, 32'h1234_5628);   // Low byte is 40
		write_reg(4'd13, 32'hffff_ff07);

		for (int k = 0; k < 16; k++)
			offer({4'he, 3'b001, 4'b0100, 1'b1, 4'd1, 4'd0, 4'(k), 8'($random(seed))},
				class_alu, 1'b0);
		// Rn and Rm sweep through r15 at the ends of both loops
		for (int k = 0; k < 16; k++)
			offer({4'he, 3'b000, 4'b0100, 1'b1, 4'(k), 4'd0, imm_amts[k % 4], 2'(k / 4), 1'b0,
				4'(14 - k)}, class_alu, 1'b0);
		for (int k = 0; k < 16; k++)
			offer({4'he, 3'b000, 4'b0100, 1'b1, 4'(k), 4'd0, amount_regs[k % 4], 1'b0, 2'(k / 4),
				1'b1, 4'(15 - k)}, class_alu, 1'b0);
		offer(32'he591_2abc, class_ldrstr, 1'b0);
		offer(32'he79f_3145, class_ldrstr, 1'b0);
		offer(32'he92d_4ff0, class_ldmstm, 1'b0);
		offer(32'he1d4_52b6, class_hdata_imm, 1'b0);
		offer(32'he1ff_f0d0, class_hdata_imm, 1'b0);
		offer(32'heaff_fffe, class_branch, 1'b0);
		offer(32'h0b00_0123, class_branch, 1'b0);

		offer(32'he281_0001, class_alu, 1'b0);
		for (int k = 0; k < 4; k++)
			offer(force_bits($random(seed), 32'h0e10_0000, 32'h0210_0000), class_alu, 1'b1);
		idle();

		for (int n = 0; n < num_random; n++)
		begin
			word = $random(seed);
			hold = ($random(seed) & 15) == 0;
			pick = $unsigned($random(seed)) % 9;
			case (pick)
				0: offer(force_bits(word, 32'h0e10_0000, 32'h0210_0000), class_alu, hold);
				1: offer(force_bits(word, 32'h0e10_0010, 32'h0010_0000), class_alu, hold);
				2: offer(force_bits(word, 32'h0e10_0090, 32'h0010_0010), class_alu, hold);
				3: offer(force_bits(word, 32'h0c00_0010, 32'h0400_0000), class_ldrstr, hold);
				4: offer(force_bits(word, 32'h0e00_0000, 32'h0800_0000), class_ldmstm, hold);
				5: offer(force_bits(word, 32'h0e50_0090, 32'h0050_0090), class_hdata_imm, hold);
				6: offer(force_bits(word, 32'h0e00_0000, 32'h0a00_0000), class_branch, hold);
				7: write_reg(word[3:0], $random(seed));
				default: idle();
			endcase
		end

		idle();
		repeat (2) @(posedge clk);
		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== design/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
	input logic clk,
	input logic reset,
	input logic stall,
	input arm_pipe_pkg::decode_in_t fetch,
	input logic wr_en,
	input arm_pipe_pkg::reg_addr_t wr_addr,
	input logic [31:0] wr_data,
	output arm_pipe_pkg::decode_out_t issue
);
	import arm_isa_pkg::*;
	import arm_pipe_pkg::*;

	insn_class_t insn_class;
	reg_addr_t rd_addr0;
	reg_addr_t rd_addr1;
	reg_addr_t rd_addr2;
	logic [31:0] rd_data0;
	logic [31:0] rd_data1;
	logic [31:0] rd_data2;
	logic [31:0] shift_operand;
	logic [31:0] shift_amount;
	logic shift_carry_in;
	logic [31:0] shift_result;
	logic shift_carry_out;

	insn_classifier u_insn_classifier (
		.insn       (fetch.insn),
		.insn_class (insn_class)
	);

	operand_shifter u_operand_shifter (
		.insn       (fetch.insn),
		.operand    (shift_operand),
		.reg_amount (shift_amount),
		.carry_in   (shift_carry_in),
		.result     (shift_result),
		.carry_out  (shift_carry_out)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.rd_addr0 (rd_addr0),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.rd_data0 (rd_data0),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	decode_stage u_decode_stage (
		.clk             (clk),
		.reset           (reset),
		.stall           (stall),
		.fetch           (fetch),
		.insn_class      (insn_class),
		.rd_addr0        (rd_addr0),
		.rd_addr1        (rd_addr1),
		.rd_addr2        (rd_addr2),
		.rd_data0        (rd_data0),
		.rd_data1        (rd_data1),
		.rd_data2        (rd_data2),
		.shift_operand   (shift_operand),
		.shift_amount    (shift_amount),
		.shift_carry_in  (shift_carry_in),
		.shift_result    (shift_result),
		.shift_carry_out (shift_carry_out),
		.issue           (issue)
	);

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input logic clk,
	input logic reset,
	input logic stall,
	input arm_pipe_pkg::decode_in_t fetch,
	input arm_isa_pkg::insn_class_t insn_class,
	output arm_pipe_pkg::reg_addr_t rd_addr0,
	output arm_pipe_pkg::reg_addr_t rd_addr1,
	output arm_pipe_pkg::reg_addr_t rd_addr2,
	input logic [31:0] rd_data0,
	input logic [31:0] rd_data1,
	input logic [31:0] rd_data2,
	output logic [31:0] shift_operand,
	output logic [31:0] shift_amount,
	output logic shift_carry_in,
	input logic [31:0] shift_result,
	input logic shift_carry_out,
	output arm_pipe_pkg::decode_out_t issue
);
	import arm_isa_pkg::*;
	import arm_pipe_pkg::*;

	insn_word_t insn;
	op2_imm_t op2_imm;
	logic regshift;
	logic [31:0] read_pc;
	logic [31:0] regs0;
	logic [31:0] regs1;
	logic [63:0] rot_pair;
	logic [31:0] rotate_res;
	logic cpsr_carry;
	decode_out_t stage_next;

	assign insn = fetch.insn;
	assign op2_imm = op2_imm_t'(insn.dp.operand2);
	assign cpsr_carry = fetch.cpsr[cpsr_c_bit];

	// The PC has run further ahead when Rs costs an extra read cycle
	assign regshift = (insn_class == class_alu && !insn.dp.imm && insn.dp.operand2[4])
		|| insn_class == class_mrcmcr;
	assign read_pc = fetch.pc + (regshift ? pc_ahead_regshift : pc_ahead_normal);

	assign regs0 = (rd_addr0 == reg_pc) ? read_pc : rd_data0;
	assign regs1 = (rd_addr1 == reg_pc) ? read_pc : rd_data1;

	// Port 2 never carries the PC
	assign shift_operand = regs1;
	assign shift_amount = rd_data2;
	assign shift_carry_in = cpsr_carry;

	// Doubled word shifted right gives the rotate in its low half
	assign rot_pair = {2{24'd0, op2_imm.imm8}} >> {op2_imm.rot, 1'b0};
	assign rotate_res = rot_pair[31:0];

	always_comb
	begin
		rd_addr0 = '0;
		rd_addr1 = '0;
		rd_addr2 = '0;
		case (insn_class)
			class_mult:
			begin
				rd_addr0 = insn.dp.operand2[3:0];   // Rm
				rd_addr1 = insn.dp.operand2[11:8];  // Rs
				rd_addr2 = insn.dp.rd;              // Accumulator Rn sits in the Rd slot
			end
			class_msr, class_msr_flags, class_bx:
				rd_addr0 = insn.dp.operand2[3:0];
			class_swp:
			begin
				rd_addr0 = insn.dp.operand2[3:0];
				rd_addr1 = insn.dp.rn;
			end
			class_hdata_reg, class_alu, class_ldrstr:
			begin
				rd_addr0 = insn.dp.rn;
				rd_addr1 = insn.dp.operand2[3:0];
				rd_addr2 = (insn_class == class_alu) ? insn.dp.operand2[11:8] : insn.dp.rd;
			end
			class_hdata_imm:
			begin
				rd_addr0 = insn.dp.rn;
				rd_addr2 = insn.dp.rd;
			end
			class_ldmstm, class_ldcstc:
				rd_addr0 = insn.dp.rn;
			class_mrcmcr:
				rd_addr0 = insn.dp.rd;
			default:
				rd_addr0 = '0;                      // Nothing to read
		endcase
	end

	always_comb
	begin
		stage_next = '0;
		stage_next.valid = fetch.valid;
		stage_next.cpsr = fetch.cpsr;
		stage_next.spsr = fetch.spsr;
		case (insn_class)
			class_mult, class_hdata_reg:
			begin
				stage_next.op0 = regs0;
				stage_next.op1 = regs1;
				stage_next.op2 = rd_data2;
			end
			class_msr, class_bx, class_mrcmcr:
				stage_next.op0 = regs0;
			class_msr_flags:
				stage_next.op0 = insn.dp.imm ? rotate_res : regs0;
			class_swp:
			begin
				stage_next.op0 = regs0;
				stage_next.op1 = regs1;
			end
			class_hdata_imm:
			begin
				stage_next.op0 = regs0;
				stage_next.op1 = {24'd0, insn.dp.operand2[11:8], insn.dp.operand2[3:0]};
				stage_next.op2 = rd_data2;
			end
			class_alu:
			begin
				stage_next.op0 = regs0;
				stage_next.op1 = insn.dp.imm ? rotate_res : shift_result;
				stage_next.carry = insn.dp.imm ? cpsr_carry : shift_carry_out;
			end
			class_ldrstr:
			begin
				stage_next.op0 = regs0;
				stage_next.op1 = insn.dp.imm ? shift_result : {20'd0, insn.dp.operand2};
				stage_next.carry = insn.dp.imm ? shift_carry_out : cpsr_carry; // I bit inverted here
				stage_next.op2 = rd_data2;
			end
			class_ldmstm:
			begin
				stage_next.op0 = regs0;
				stage_next.op1 = {16'd0, insn.dp.rd, insn.dp.operand2}; // Register list
			end
			class_branch:
				stage_next.op0 = {{6{insn.br.offset[23]}}, insn.br.offset, 2'b00};
			class_ldcstc:
			begin
				stage_next.op0 = regs0;
				stage_next.op1 = {24'd0, op2_imm.imm8};
			end
			default:
				stage_next.op0 = '0;
		endcase
	end

	// Under stall the stage holds and the offered instruction is lost
	always_ff @(posedge clk)
	begin
		if (reset)
			issue <= '0;
		else if (!stall)
			issue <= stage_next;
	end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic reset,
	input arm_pipe_pkg::reg_addr_t rd_addr0,
	input arm_pipe_pkg::reg_addr_t rd_addr1,
	input arm_pipe_pkg::reg_addr_t rd_addr2,
	output logic [31:0] rd_data0,
	output logic [31:0] rd_data1,
	output logic [31:0] rd_data2,
	input logic wr_en,
	input arm_pipe_pkg::reg_addr_t wr_addr,
	input logic [31:0] wr_data
);
	import arm_isa_pkg::*;
	import arm_pipe_pkg::*;

	logic [31:0] regs [num_gprs];

	// The PC is not stored here, so index 15 reads as zero
	function automatic logic [31:0] read_reg(reg_addr_t addr);
		if (addr == reg_pc)
			return 32'd0;
		return regs[addr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_gprs; i++)
				regs[i] <= 32'd0;
		end
		else if (wr_en && wr_addr != reg_pc)
			regs[wr_addr] <= wr_data;    // Writes to r15 are dropped
	end

	assign rd_data0 = read_reg(rd_addr0);
	assign rd_data1 = read_reg(rd_addr1);
	assign rd_data2 = read_reg(rd_addr2);

endmodule

// ==== design/operand_shifter.sv ====
`timescale 1ns/1ps

module operand_shifter (
	input arm_isa_pkg::insn_word_t insn,
	input logic [31:0] operand,
	input logic [31:0] reg_amount,
	input logic carry_in,
	output logic [31:0] result,
	output logic carry_out
);
	import arm_isa_pkg::*;

	op2_reg_t sh;
	logic [7:0] amount;
	logic is_32;
	logic over_32;
	logic is_ror;
	logic fill_bit;
	logic [32:0] st0;
	logic [32:0] st16;
	logic [32:0] st8;
	logic [32:0] st4;
	logic [32:0] st2;
	logic [32:0] st1;
	logic [32:0] lsl_full;

	assign sh = op2_reg_t'(insn.dp.operand2);

	// Only the low byte of Rs counts
	always_comb
	begin
		if (sh.by_reg)
			amount = reg_amount[7:0];
		else if (sh.shift_imm == 5'd0 && (sh.kind == shift_lsr || sh.kind == shift_asr))
			amount = 8'd32;                      // Immediate 0 encodes a shift by 32
		else
			amount = {3'b000, sh.shift_imm};
	end

	assign is_32 = (amount == 8'd32);
	assign over_32 = (amount > 8'd32);
	assign is_ror = (sh.kind == shift_ror);
	assign fill_bit = (sh.kind == shift_asr) && operand[31];

	// The carry rides in bit 0 and picks up the last bit shifted out
	assign st0 = {operand, carry_in};
	assign st16 = amount[4] ? {is_ror ? st0[16:1] : {16{fill_bit}}, st0[32:16]} : st0;
	assign st8 = amount[3] ? {is_ror ? st16[8:1] : {8{fill_bit}}, st16[32:8]} : st16;
	assign st4 = amount[2] ? {is_ror ? st8[4:1] : {4{fill_bit}}, st8[32:4]} : st8;
	assign st2 = amount[1] ? {is_ror ? st4[2:1] : {2{fill_bit}}, st4[32:2]} : st4;
	assign st1 = amount[0] ? {is_ror ? st2[1] : fill_bit, st2[32:1]} : st2;

	assign lsl_full = {carry_in, operand} << amount[4:0];

	always_comb
	begin
		case (sh.kind)
			shift_lsl:
			begin
				if (over_32)
					{carry_out, result} = 33'd0;
				else if (is_32)
					{carry_out, result} = {operand[0], 32'd0};
				else
					{carry_out, result} = lsl_full;
			end
			shift_lsr, shift_asr:
			begin
				if (over_32)
					{carry_out, result} = {fill_bit, {32{fill_bit}}};
				else if (is_32)
					{carry_out, result} = {operand[31], {32{fill_bit}}};
				else
					{result, carry_out} = st1;
			end
			default:
			begin
				if (!sh.by_reg && sh.shift_imm == 5'd0)
					{carry_out, result} = {operand[0], carry_in, operand[31:1]}; // RRX
				else if (amount != 8'd0 && amount[4:0] == 5'd0)
					{carry_out, result} = {operand[31], operand}; // Whole turns
				else
					{result, carry_out} = st1;
			end
		endcase
	end

endmodule

// ==== design/insn_classifier.sv ====
`timescale 1ns/1ps

module insn_classifier (
	input arm_isa_pkg::insn_word_t insn,
	output arm_isa_pkg::insn_class_t insn_class
);
	import arm_isa_pkg::*;

	// The first matching pattern wins, so the narrow encodings come before the wide ones
	always_comb
	begin
		casez (insn)
			32'b????_0000_00??_????_????_????_1001_????:
				insn_class = class_mult;         // Must be tested before ALU
			32'b????_0001_0?00_1111_????_0000_0000_0000:
				insn_class = class_mrs;
			32'b????_0001_0?10_1001_1111_0000_0000_????:
				insn_class = class_msr;
			32'b????_00?1_0?10_1000_1111_????_????_????:
				insn_class = class_msr_flags;
			32'b????_0001_0?00_????_????_0000_1001_????:
				insn_class = class_swp;
			32'b????_0001_0010_1111_1111_1111_0001_????:
				insn_class = class_bx;
			32'b????_000?_?0??_????_????_0000_1??1_????:
				insn_class = class_hdata_reg;    // Also sits inside the ALU space
			32'b????_000?_?1??_????_????_????_1??1_????:
				insn_class = class_hdata_imm;
			32'b????_011?_????_????_????_????_???1_????:
				insn_class = class_ldrstr_undef; // Must be tested before LDR and STR
			32'b????_00??_????_????_????_????_????_????:
				insn_class = class_alu;
			32'b????_01??_????_????_????_????_????_????:
				insn_class = class_ldrstr;
			32'b????_100?_????_????_????_????_????_????:
				insn_class = class_ldmstm;
			32'b????_101?_????_????_????_????_????_????:
				insn_class = class_branch;
			32'b????_110?_????_????_????_????_????_????:
				insn_class = class_ldcstc;
			32'b????_1110_????_????_????_????_???0_????:
				insn_class = class_cdp;
			32'b????_1110_????_????_????_????_???1_????:
				insn_class = class_mrcmcr;
			32'b????_1111_????_????_????_????_????_????:
				insn_class = class_swi;
			default:
				insn_class = class_undefined;
		endcase
	end

endmodule

// ==== design/arm_pipe_pkg.sv ====
package arm_pipe_pkg;

	typedef logic [3:0] reg_addr_t;

	// Registers r0 to r14 live in the register file
	localparam int num_gprs = 15;

	// What the fetch stage hands over for one instruction
	typedef struct packed {
		logic valid;
		arm_isa_pkg::insn_word_t insn;
		logic [31:0] pc;
		logic [31:0] cpsr;
		logic [31:0] spsr;
	} decode_in_t;

	// Operands and status words for the execute stage
	typedef struct packed {
		logic valid;
		logic [31:0] op0;        // Usually Rn or the branch offset
		logic [31:0] op1;        // Usually the second operand
		logic [31:0] op2;        // Third operand such as store data
		logic carry;             // Shifter carry for the flags
		logic [31:0] cpsr;
		logic [31:0] spsr;
	} decode_out_t;

endpackage

// ==== design/arm_isa_pkg.sv ====
package arm_isa_pkg;

	// Instruction classes in the order the classifier tests them
	typedef enum logic [4:0] {
		class_mult,          // Multiply and multiply-accumulate
		class_mrs,           // PSR to register
		class_msr,           // Register to whole PSR
		class_msr_flags,     // Register or immediate to PSR flags
		class_swp,           // Atomic swap
		class_bx,            // Branch and exchange
		class_hdata_reg,     // Halfword transfer with register offset
		class_hdata_imm,     // Halfword transfer with immediate offset
		class_ldrstr_undef,  // Register-shifted single transfer is undefined
		class_alu,           // Data processing
		class_ldrstr,        // Single data transfer
		class_ldmstm,        // Block data transfer
		class_branch,        // Branch and branch with link
		class_ldcstc,        // Coprocessor data transfer
		class_cdp,           // Coprocessor data operation
		class_mrcmcr,        // Coprocessor register transfer
		class_swi,           // Software interrupt
		class_undefined
	} insn_class_t;

	typedef enum logic [1:0] {
		shift_lsl = 2'b00,
		shift_lsr = 2'b01,
		shift_asr = 2'b10,
		shift_ror = 2'b11
	} shift_type_t;

	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] group;       // Zero for data processing
		logic imm;               // Operand 2 is a rotated immediate
		logic [3:0] opcode;
		logic set;               // Update the condition flags
		logic [3:0] rn;
		logic [3:0] rd;
		logic [11:0] operand2;
	} dp_view_t;

	typedef struct packed {
		logic [3:0] cond;
		logic [2:0] group;       // Reads 101 for a branch
		logic link;
		logic [23:0] offset;     // Word offset from the read-ahead PC
	} branch_view_t;

	// The same word seen as data processing or as a branch
	typedef union packed {
		dp_view_t dp;
		branch_view_t br;
	} insn_word_t;

	// Operand 2 when it names a shifted register
	typedef struct packed {
		logic [4:0] shift_imm;
		shift_type_t kind;
		logic by_reg;            // Amount comes from Rs
		logic [3:0] rm;
	} op2_reg_t;

	// Operand 2 when it holds an 8-bit immediate and a rotate
	typedef struct packed {
		logic [3:0] rot;
		logic [7:0] imm8;
	} op2_imm_t;

	localparam int cpsr_c_bit = 29;
	localparam logic [31:0] pc_ahead_normal = 32'd8;
	localparam logic [31:0] pc_ahead_regshift = 32'd12;
	localparam logic [3:0] reg_pc = 4'd15;

endpackage
